// ==== tcm_subsystem.f ====
+incdir+include
source/tcm_pkg.sv
source/tcm_ctrl.sv
source/tcm_arbiter.sv
source/tcm_subsystem.sv
verif/tcm_subsystem_tb.sv

// ==== Bender.yml ====
package:
  name: tcm_subsystem

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/tcm_pkg.sv
      - source/tcm_ctrl.sv
      - source/tcm_arbiter.sv
      - source/tcm_subsystem.sv

  - target: test
    include_dirs:
      - include
    files:
      - verif/tcm_subsystem_tb.sv

// ==== verif/tcm_subsystem_tb.sv ====
// Bank words are only read after they were written, since the bank arrays start unknown
`include "tcm_params_pkg_params.svh"

module tcm_subsystem_tb;

   localparam int DW = `TCM_DATA_WIDTH;
   localparam int WORDS = 1 << (`TCM_ADDR_WIDTH - 2);
   // Accesses per test: 16, 24, 6, 6, 8, 8
   localparam int ACCESSES = 68;
   localparam int RESET_CYCLES = 16;
   localparam int CYCLE_LIMIT = ACCESSES * 4 + RESET_CYCLES;

   logic              clk;
   logic              rst_n;
   tcm_pkg::cpu_req_t code_req;
   tcm_pkg::cpu_rsp_t code_rsp;
   tcm_pkg::cpu_req_t data_req;
   tcm_pkg::cpu_rsp_t data_rsp;

   // Reference banks
   logic [DW-1:0] code_mem [WORDS];
   logic [DW-1:0] data_mem [WORDS];

   // Expected read data per port
   logic [DW-1:0] code_q [$];
   logic [DW-1:0] data_q [$];
   logic [DW-1:0] code_head;
   logic [DW-1:0] data_head;
   logic          code_chk;
   logic          data_chk;

   // Acceptance seen at the falling edge before the accepting edge
   logic          code_acc;
   logic          data_acc;

   logic [31:0]   lfsr;
   int            err_cnt;
   int            check_cnt;
   int            test_cnt;
   int            test_err0;
   int            cycle_cnt;
   string         test_name;

   // Words stored in the first test, reused later
   logic [DW-1:0] code_addr [4];
   logic [DW-1:0] data_addr [4];

   tcm_subsystem UUT (
      .clk      (clk),
      .rst_n    (rst_n),
      .code_req (code_req),
      .code_rsp (code_rsp),
      .data_req (data_req),
      .data_rsp (data_rsp)
   );

   always #4 clk = ~clk;

   // Fibonacci LFSR, taps 32 22 2 1, one step per bit
   function automatic logic [31:0] lfsr_bits(input int n);
      logic [31:0] val;
      logic        fb;
      val = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         val  = {val[30:0], fb};
      end
      return val;
   endfunction

   // Random word address in one region, upper bits random too
   function automatic logic [DW-1:0] rand_addr(input logic [3:0] nibble);
      logic [15:0] mid;
      logic [9:0]  word;
      mid  = 16'(lfsr_bits(16));
      word = 10'(lfsr_bits(10));
      return {nibble, mid, word, 2'b00};
   endfunction

   function automatic tcm_pkg::region_e region_of(input logic [DW-1:0] addr);
      tcm_pkg::region_e r;
      if (addr[31:28] == `TCM_REGION_CODE) begin
         r = tcm_pkg::region_code;
      end else if (addr[31:28] == `TCM_REGION_DATA) begin
         r = tcm_pkg::region_data;
      end else begin
         r = tcm_pkg::region_none;
      end
      return r;
   endfunction

   // One accepted access on the model; returns next cycle's read data
   function automatic logic [DW-1:0] model_access(input logic [DW-1:0] addr,
                                                  input logic [DW-1:0] wdata,
                                                  input logic [3:0]    bytesel);
      tcm_pkg::region_e r;
      logic [DW-1:0]    word;
      logic [9:0]       idx;
      r    = region_of(addr);
      idx  = addr[`TCM_ADDR_WIDTH-1:2];
      word = '0;
      if (r == tcm_pkg::region_code) begin
         word = code_mem[idx];
      end else if (r == tcm_pkg::region_data) begin
         word = data_mem[idx];
      end
      for (int i = 0; i < 4; i++) begin
         if (bytesel[i]) begin
            word[8*i +: 8] = wdata[8*i +: 8];
         end
      end
      if (r == tcm_pkg::region_code) begin
         code_mem[idx] = word;
      end else if (r == tcm_pkg::region_data) begin
         data_mem[idx] = word;
      end else begin
         // Sink drops writes and reads zero
         word = '0;
      end
      return word;
   endfunction

   always @(negedge clk) begin
      code_acc = rst_n && code_rsp.early_ready;
      data_acc = rst_n && data_rsp.early_ready;
   end

   // Model update at each accepting edge
   always @(posedge clk) begin
      // Head was checked by the assertions at this edge
      if (code_chk) begin
         void'(code_q.pop_front());
         check_cnt++;
      end
      if (data_chk) begin
         void'(data_q.pop_front());
         check_cnt++;
      end
      code_chk = 1'b0;
      data_chk = 1'b0;
      if (data_acc) begin
         data_q.push_back(model_access(data_req.addr, data_req.wdata, data_req.bytesel));
         data_chk = 1'b1;
      end
      if (code_acc) begin
         // Fetch port is read-only whatever it drives
         code_q.push_back(model_access(code_req.addr, '0, 4'b0000));
         code_chk = 1'b1;
      end
      code_head = (code_q.size() > 0) ? code_q[0] : '0;
      data_head = (data_q.size() > 0) ? data_q[0] : '0;
   end

   fetch_rdata: assert property (@(posedge clk) disable iff (!rst_n)
      code_chk |-> code_rsp.rdata == code_head)
      else begin
         err_cnt++;
         $display("ERROR %s fetch rdata expected %h actual %h", test_name,
                  $sampled(code_head), $sampled(code_rsp.rdata));
      end

   load_rdata: assert property (@(posedge clk) disable iff (!rst_n)
      data_chk |-> data_rsp.rdata == data_head)
      else begin
         err_cnt++;
         $display("ERROR %s load rdata expected %h actual %h", test_name,
                  $sampled(data_head), $sampled(data_rsp.rdata));
      end

   // Fetch never accepted into the bank that the data port holds
   shared_bank: assert property (@(posedge clk) disable iff (!rst_n)
      !(code_rsp.early_ready && data_req.req &&
        region_of(code_req.addr) != tcm_pkg::region_none &&
        region_of(code_req.addr) == region_of(data_req.addr)))
      else begin
         err_cnt++;
         $display("%s: fetch port accepted while the data port held its bank", test_name);
      end

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt > CYCLE_LIMIT) begin
         $display("Timeout: run still busy after %0d cycles", CYCLE_LIMIT);
         $display("Errors found");
         $finish;
      end
   end

   // Starts at 1 after an edge, ends at 1 after the accepting edge
   task automatic data_access(input logic [DW-1:0] addr, input logic [DW-1:0] wdata,
                              input logic [3:0] bytesel, output int cycles);
      logic acc;
      acc      = 1'b0;
      cycles   = 0;
      data_req = '{req: 1'b1, addr: addr, wdata: wdata, bytesel: bytesel};
      while (!acc) begin
         @(negedge clk);
         acc = data_rsp.early_ready;
         @(posedge clk);
         #1;
         cycles++;
      end
      data_req.req = 1'b0;
   endtask

   // Junk write lanes must never reach a bank
   task automatic fetch_access(input logic [DW-1:0] addr, input logic [DW-1:0] junk,
                               output int cycles);
      logic acc;
      acc      = 1'b0;
      cycles   = 0;
      code_req = '{req: 1'b1, addr: addr, wdata: junk, bytesel: 4'hf};
      while (!acc) begin
         @(negedge clk);
         acc = code_rsp.early_ready;
         @(posedge clk);
         #1;
         cycles++;
      end
      code_req.req = 1'b0;
   endtask

   task automatic expect_cycles(input string what, input int exp, input int act);
      latency: assert (act == exp) else begin
         err_cnt++;
         $display("ERROR %s %s cycles expected %0d actual %0d", test_name, what, exp, act);
      end
   endtask

   task automatic start_test(input string name);
      test_name = name;
      test_err0 = err_cnt;
   endtask

   task automatic finish_test();
      repeat (2) @(posedge clk);
      #1;
      test_cnt++;
      $display("test %s done with %0d errors", test_name, err_cnt - test_err0);
   endtask

   initial begin
      int            cyc_d;
      int            cyc_c;
      logic [DW-1:0] addr;
      logic [DW-1:0] wdata;
      logic [DW-1:0] junk;
      logic [DW-1:0] lane_addr [8];
      logic [DW-1:0] junk_list [6];
      clk       = 1'b0;
      rst_n     = 1'b0;
      code_req  = '0;
      data_req  = '0;
      lfsr      = 32'h178b_6785;
      code_chk  = 1'b0;
      data_chk  = 1'b0;
      code_acc  = 1'b0;
      data_acc  = 1'b0;
      err_cnt   = 0;
      check_cnt = 0;
      test_cnt  = 0;
      cycle_cnt = 0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rst_n = 1'b1;

      // Stores into both banks, then fetches with uncontended latency
      start_test("write_then_fetch");
      for (int i = 0; i < 4; i++) begin
         code_addr[i] = rand_addr(`TCM_REGION_CODE);
         data_access(code_addr[i], lfsr_bits(32), 4'hf, cyc_d);
         expect_cycles("code store", 1 + `TCM_CODE_WAIT, cyc_d);
      end
      for (int i = 0; i < 4; i++) begin
         data_addr[i] = rand_addr(`TCM_REGION_DATA);
         data_access(data_addr[i], lfsr_bits(32), 4'hf, cyc_d);
         expect_cycles("data store", 1 + `TCM_DATA_WAIT, cyc_d);
      end
      for (int i = 0; i < 8; i++) begin
         addr = (i < 4) ? code_addr[i] : data_addr[i-4];
         fetch_access(addr, lfsr_bits(32), cyc_c);
         expect_cycles("fetch", (i < 4) ? 1 + `TCM_CODE_WAIT : 1 + `TCM_DATA_WAIT, cyc_c);
      end
      finish_test();

      // Full words first so every lane is known
      start_test("byte_lanes");
      for (int i = 0; i < 8; i++) begin
         lane_addr[i] = rand_addr(`TCM_REGION_DATA);
         data_access(lane_addr[i], lfsr_bits(32), 4'hf, cyc_d);
      end
      for (int i = 0; i < 8; i++) begin
         data_access(lane_addr[i], lfsr_bits(32), 4'(lfsr_bits(4)), cyc_d);
      end
      for (int i = 0; i < 8; i++) begin
         data_access(lane_addr[i], '0, 4'b0000, cyc_d);
      end
      finish_test();

      // Same word from both ports, data port store wins
      start_test("same_bank");
      for (int i = 0; i < 3; i++) begin
         addr  = (i < 2) ? code_addr[i] : data_addr[0];
         wdata = lfsr_bits(32);
         junk  = lfsr_bits(32);
         fork
            data_access(addr, wdata, 4'hf, cyc_d);
            fetch_access(addr, junk, cyc_c);
         join
         data_first: assert (cyc_d < cyc_c) else begin
            err_cnt++;
            $display("%s: data port was not accepted before the fetch", test_name);
         end
      end
      finish_test();

      // Data port into code bank, fetch into data bank
      start_test("crossed");
      for (int i = 0; i < 3; i++) begin
         wdata = lfsr_bits(32);
         junk  = lfsr_bits(32);
         fork
            data_access(code_addr[i], wdata, 4'(lfsr_bits(4)), cyc_d);
            fetch_access(data_addr[i], junk, cyc_c);
         join
         expect_cycles("crossed store", 1 + `TCM_CODE_WAIT, cyc_d);
         expect_cycles("crossed fetch", 1 + `TCM_DATA_WAIT, cyc_c);
      end
      finish_test();

      // Sink shares low bits with a known data bank word
      start_test("unmapped");
      for (int i = 0; i < 2; i++) begin
         addr        = rand_addr((i == 0) ? 4'h1 : 4'hf);
         addr[11:0]  = data_addr[i][11:0];
         data_access(addr, lfsr_bits(32), 4'hf, cyc_d);
         expect_cycles("sink store", 1, cyc_d);
         data_access(addr, '0, 4'b0000, cyc_d);
         fetch_access(addr, lfsr_bits(32), cyc_c);
         expect_cycles("sink fetch", 1, cyc_c);
         data_access(data_addr[i], '0, 4'b0000, cyc_d);
      end
      finish_test();

      // Fetch stream across both banks while loads come and go
      start_test("fetch_stream");
      for (int i = 0; i < 6; i++) begin
         junk_list[i] = lfsr_bits(32);
      end
      wdata = lfsr_bits(32);
      fork
         begin
            for (int i = 0; i < 6; i++) begin
               addr = (i % 2 == 0) ? code_addr[i%4] : data_addr[i%4];
               fetch_access(addr, junk_list[i], cyc_c);
            end
         end
         begin
            data_access(code_addr[1], '0, 4'b0000, cyc_d);
            data_access(data_addr[2], wdata, 4'hf, cyc_d);
         end
      join
      finish_test();

      $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

// ==== source/tcm_subsystem.sv ====
// Two banks behind one arbiter; nothing is queued, requesters hold until early_ready
`include "tcm_params_pkg_params.svh"

module tcm_subsystem (
   input  logic              clk,
   input  logic              rst_n,
   // Instruction fetch port
   input  tcm_pkg::cpu_req_t code_req,
   output tcm_pkg::cpu_rsp_t code_rsp,
   // Load/store port
   input  tcm_pkg::cpu_req_t data_req,
   output tcm_pkg::cpu_rsp_t data_rsp
);

   // Arbiter to bank links
   tcm_pkg::tcm_req_t bank_code_req;
   tcm_pkg::tcm_req_t bank_data_req;
   tcm_pkg::tcm_rsp_t bank_code_rsp;
   tcm_pkg::tcm_rsp_t bank_data_rsp;

   // Region decode, priority and read-data routing
   tcm_arbiter u_tcm_arbiter (
      .clk           (clk),
      .rst_n         (rst_n),
      .code_req      (code_req),
      .data_req      (data_req),
      .code_rsp      (code_rsp),
      .data_rsp      (data_rsp),
      .bank_code_req (bank_code_req),
      .bank_data_req (bank_data_req),
      .bank_code_rsp (bank_code_rsp),
      .bank_data_rsp (bank_data_rsp)
   );

   // Code bank at region 0x0
   // One extra wait state
   tcm_ctrl #(
      .WAIT_STATES (`TCM_CODE_WAIT)
   ) u_tcm_code (
      .clk   (clk),
      .rst_n (rst_n),
      .req   (bank_code_req),
      .rsp   (bank_code_rsp)
   );

   // Data bank at region 0x2
   // Zero wait states
   tcm_ctrl #(
      .WAIT_STATES (`TCM_DATA_WAIT)
   ) u_tcm_data (
      .clk   (clk),
      .rst_n (rst_n),
      .req   (bank_data_req),
      .rsp   (bank_data_rsp)
   );

endmodule

// ==== source/tcm_arbiter.sv ====
// Data port always wins a shared bank; fetch port is read-only and unmapped regions read zero
`include "tcm_params_pkg_params.svh"

module tcm_arbiter (
   input  logic              clk,
   input  logic              rst_n,
   input  tcm_pkg::cpu_req_t code_req,
   input  tcm_pkg::cpu_req_t data_req,
   output tcm_pkg::cpu_rsp_t code_rsp,
   output tcm_pkg::cpu_rsp_t data_rsp,
   output tcm_pkg::tcm_req_t bank_code_req,
   output tcm_pkg::tcm_req_t bank_data_req,
   input  tcm_pkg::tcm_rsp_t bank_code_rsp,
   input  tcm_pkg::tcm_rsp_t bank_data_rsp
);

   // Decoded region per port
   tcm_pkg::region_e code_region;
   tcm_pkg::region_e data_region;

   // Port to bank request matrix
   logic             d_code;
   logic             d_data;
   logic             c_code;
   logic             c_data;

   // Acceptance per port
   logic             code_ready;
   logic             data_ready;

   // Owner of next cycle's read data, per port
   tcm_pkg::region_e code_src_q;
   tcm_pkg::region_e data_src_q;

   // Top nibble to region
   function automatic tcm_pkg::region_e decode(input logic [`TCM_DATA_WIDTH-1:0] addr);
      tcm_pkg::region_e region;
      case (addr[`TCM_DATA_WIDTH-1 -: 4])
         `TCM_REGION_CODE: region = tcm_pkg::region_code;
         `TCM_REGION_DATA: region = tcm_pkg::region_data;
         // Everything else lands in the sink
         default:          region = tcm_pkg::region_none;
      endcase
      return region;
   endfunction

   assign code_region = decode(code_req.addr);
   assign data_region = decode(data_req.addr);

   assign d_code = data_req.req && (data_region == tcm_pkg::region_code);
   assign d_data = data_req.req && (data_region == tcm_pkg::region_data);
   assign c_code = code_req.req && (code_region == tcm_pkg::region_code);
   assign c_data = code_req.req && (code_region == tcm_pkg::region_data);

   // Code bank: data port first, then fetch
   always_comb begin
      bank_code_req.en      = 1'b0;
      bank_code_req.addr    = code_req.addr[`TCM_ADDR_WIDTH-1:0];
      bank_code_req.din     = '0;
      bank_code_req.bytesel = '0;
      if (d_code) begin
         // Load/store into code space, may write
         bank_code_req.en      = 1'b1;
         bank_code_req.addr    = data_req.addr[`TCM_ADDR_WIDTH-1:0];
         bank_code_req.din     = data_req.wdata;
         bank_code_req.bytesel = data_req.bytesel;
      end else if (c_code) begin
         // Plain fetch, never writes
         bank_code_req.en = 1'b1;
      end
   end

   // Data bank: same priority
   always_comb begin
      bank_data_req.en      = 1'b0;
      bank_data_req.addr    = data_req.addr[`TCM_ADDR_WIDTH-1:0];
      bank_data_req.din     = '0;
      bank_data_req.bytesel = '0;
      if (d_data) begin
         bank_data_req.en      = 1'b1;
         bank_data_req.din     = data_req.wdata;
         bank_data_req.bytesel = data_req.bytesel;
      end else if (c_data) begin
         // Fetch from data space, crossed or alone
         bank_data_req.en   = 1'b1;
         bank_data_req.addr = code_req.addr[`TCM_ADDR_WIDTH-1:0];
      end
   end

   // Fetch acceptance
   // Held low while the data port owns the wanted bank
   always_comb begin
      code_ready = 1'b0;
      if (code_req.req) begin
         case (code_region)
            tcm_pkg::region_code: code_ready = !d_code && bank_code_rsp.ready_nxt;
            tcm_pkg::region_data: code_ready = !d_data && bank_data_rsp.ready_nxt;
            // Sink accepts at once
            default:              code_ready = 1'b1;
         endcase
      end
   end

   // Data port acceptance, never blocked by fetch
   always_comb begin
      data_ready = 1'b0;
      if (data_req.req) begin
         case (data_region)
            tcm_pkg::region_code: data_ready = bank_code_rsp.ready_nxt;
            tcm_pkg::region_data: data_ready = bank_data_rsp.ready_nxt;
            default:              data_ready = 1'b1;
         endcase
      end
   end

   // Latch read-data ownership at each edge
   // Survives the requester dropping or changing its address
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         code_src_q <= tcm_pkg::region_none;
         data_src_q <= tcm_pkg::region_none;
      end else begin
         code_src_q <= code_ready ? code_region : tcm_pkg::region_none;
         data_src_q <= data_ready ? data_region : tcm_pkg::region_none;
      end
   end

   // Fetch read data steering
   always_comb begin
      case (code_src_q)
         tcm_pkg::region_code: code_rsp.rdata = bank_code_rsp.dout;
         tcm_pkg::region_data: code_rsp.rdata = bank_data_rsp.dout;
         // Sink or idle reads zero
         default:              code_rsp.rdata = '0;
      endcase
      code_rsp.early_ready = code_ready;
   end

   // Load read data steering
   always_comb begin
      case (data_src_q)
         tcm_pkg::region_code: data_rsp.rdata = bank_code_rsp.dout;
         tcm_pkg::region_data: data_rsp.rdata = bank_data_rsp.dout;
         default:              data_rsp.rdata = '0;
      endcase
      data_rsp.early_ready = data_ready;
   end

endmodule

// ==== source/tcm_ctrl.sv ====
// Single-port bank; en and inputs must stay stable until ready_nxt, no reset or preload of the array
`include "tcm_params_pkg_params.svh"

module tcm_ctrl #(
   parameter int WAIT_STATES = 0
) (
   input  logic              clk,
   input  logic              rst_n,
   input  tcm_pkg::tcm_req_t req,
   output tcm_pkg::tcm_rsp_t rsp
);

   // Word count from the byte address width
   localparam int WORD_BITS = `TCM_ADDR_WIDTH - 2;
   localparam int WORDS     = 1 << WORD_BITS;

   // Counter needs at least one bit even with no wait states
   localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;
   localparam logic [CNT_W-1:0] WAIT_LAST = CNT_W'(WAIT_STATES);

   // Storage
   logic [`TCM_DATA_WIDTH-1:0] mem [WORDS];

   // Word index, byte offset bits dropped
   logic [WORD_BITS-1:0]       word_idx;

   // Cycles spent with en high so far
   logic [CNT_W-1:0]           wait_cnt;

   // Early ready and acceptance
   logic                       ready_nxt;
   logic                       accept;

   // Stored word with the write lanes merged in
   logic [`TCM_DATA_WIDTH-1:0] merged_word;

   // Registered read data
   logic [`TCM_DATA_WIDTH-1:0] dout_q;

   assign word_idx = req.addr[`TCM_ADDR_WIDTH-1:2];

   // Ready in the (WAIT_STATES+1)-th cycle of a held request
   assign ready_nxt = req.en && (wait_cnt == WAIT_LAST);

   // Requester samples ready at this same edge
   assign accept = ready_nxt;

   // Wait-state counter
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wait_cnt <= '0;
      end else if (!req.en || accept) begin
         // Restart on drop or after each accepted access
         wait_cnt <= '0;
      end else begin
         wait_cnt <= wait_cnt + 1'b1;
      end
   end

   // Merge write lanes over the current word
   always_comb begin
      for (int i = 0; i < `TCM_BYTE_LANES; i++) begin
         if (req.bytesel[i]) begin
            merged_word[8*i +: 8] = req.din[8*i +: 8];
         end else begin
            merged_word[8*i +: 8] = mem[word_idx][8*i +: 8];
         end
      end
   end

   // Byte-lane writes at the accepting edge
   always_ff @(posedge clk) begin
      if (accept) begin
         for (int i = 0; i < `TCM_BYTE_LANES; i++) begin
            if (req.bytesel[i]) begin
               mem[word_idx][8*i +: 8] <= req.din[8*i +: 8];
            end
         end
      end
   end

   // Read data follows acceptance by one cycle
   // Shows the word after any write in the same access
   always_ff @(posedge clk) begin
      if (accept) begin
         dout_q <= merged_word;
      end
   end

   // Holds last read word between accesses
   assign rsp.dout      = dout_q;
   assign rsp.ready_nxt = ready_nxt;

endmodule

// ==== source/tcm_pkg.sv ====
// Struct layouts follow the macro widths; bytesel all zero on a request means read
`include "tcm_params_pkg_params.svh"

package tcm_pkg;

   // Address region seen by one CPU port
   // region_none goes to the zero sink
   typedef enum logic [1:0] {
      region_code,
      region_data,
      region_none
   } region_e;

   // CPU side request, held until early_ready
   typedef struct packed {
      logic                           req;
      logic [`TCM_DATA_WIDTH-1:0]     addr;
      logic [`TCM_DATA_WIDTH-1:0]     wdata;
      logic [`TCM_BYTE_LANES-1:0]     bytesel;
   } cpu_req_t;

   // CPU side response
   // rdata valid in the cycle after acceptance
   typedef struct packed {
      logic [`TCM_DATA_WIDTH-1:0]     rdata;
      logic                           early_ready;
   } cpu_rsp_t;

   // Bank side request, local byte address only
   typedef struct packed {
      logic                           en;
      logic [`TCM_ADDR_WIDTH-1:0]     addr;
      logic [`TCM_DATA_WIDTH-1:0]     din;
      logic [`TCM_BYTE_LANES-1:0]     bytesel;
   } tcm_req_t;

   // Bank side response
   typedef struct packed {
      logic [`TCM_DATA_WIDTH-1:0]     dout;
      logic                           ready_nxt;
   } tcm_rsp_t;

endpackage

// ==== include/tcm_params_pkg_params.svh ====
// Fixed 32-bit words with 4 byte lanes; regions decode from the top nibble only
`ifndef TCM_PARAMS_PKG_PARAMS_SVH
`define TCM_PARAMS_PKG_PARAMS_SVH

// CPU and bank word width
`define TCM_DATA_WIDTH 32

// Byte lanes per word, one write strobe each
`define TCM_BYTE_LANES 4

// Byte address bits that reach a bank (1024 words)
`define TCM_ADDR_WIDTH 12

// Top-nibble region codes
`define TCM_REGION_CODE 4'h0
`define TCM_REGION_DATA 4'h2

// Wait states per bank
// Code bank needs one extra cycle, data bank answers at once
`define TCM_CODE_WAIT 1
`define TCM_DATA_WAIT 0

`endif
